// ==== switch_pkg.sv ====
////////////////////////////////////////////////////////////
// Shared widths, address map and response codes for the
// write side of the crossbar master port
////////////////////////////////////////////////////////////

`default_nettype none

package switch_pkg;

    // Topology and field widths
    localparam int SLV_NB   = 4;
    localparam int ADDR_W   = 16;
    localparam int ID_W     = 4;
    localparam int DATA_W   = 8;

    // Each slave owns one 4 KB region, slave k at k << REGION_W
    localparam int REGION_W = 12;

    // Address channel word is {id, addr}
    localparam int AWCH_W   = ID_W + ADDR_W;

    // Response channel word is {resp, id}
    localparam int BCH_W    = 2 + ID_W;

    localparam logic [1:0] RESP_OKAY   = 2'd0;
    localparam logic [1:0] RESP_DECERR = 2'd3;

    typedef logic [SLV_NB-1:0] slv_mask_t;
    typedef logic [ID_W-1:0]   id_t;
    typedef logic [ADDR_W-1:0] addr_t;

endpackage

`default_nettype wire

// ==== aw_decoder.sv ====
////////////////////////////////////////////////////////////
// Write address decode against the slave map and route mask,
// with a fake handshake for unmapped addresses
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module aw_decoder
    import switch_pkg::*;
#(
    parameter slv_mask_t MST_ROUTES = 4'b1111
)(
    input  wire                     aclk,
    input  wire                     aresetn,
    input  wire                     i_awvalid,
    input  wire        [AWCH_W-1:0] i_awch,
    input  wire  slv_mask_t         i_awready_slv,
    input  wire                     i_sel_full,
    input  wire                     i_err_full,
    output slv_mask_t               o_slv_awvalid,
    output logic                    o_awready,
    output slv_mask_t               o_sel,
    output logic                    o_sel_push,
    output logic                    o_misroute,
    output id_t                     o_err_id
);

    localparam int REG_IDX_W = ADDR_W - REGION_W;

    addr_t     addr;
    slv_mask_t target;
    logic      misroute_q;

    assign addr = i_awch[ADDR_W-1:0];

    // Region index in the upper address bits, allowed routes only
    always_comb begin
        for (int k = 0; k < SLV_NB; k++) begin
            target[k] = MST_ROUTES[k] &&
                        (addr[ADDR_W-1:REGION_W] == REG_IDX_W'(k));
        end
    end

    // No strobe while the select queue cannot take the route
    assign o_slv_awvalid = target & {SLV_NB{i_awvalid & ~i_sel_full}};

    assign o_awready = (|target) ? (|(target & i_awready_slv)) & ~i_sel_full
                                 : misroute_q;

    // Zero mask is queued too, so its data beats get sunk
    assign o_sel      = target;
    assign o_sel_push = i_awvalid & o_awready;

    ////////////////////////////////////////////////////////////
    // Misroute pulse
    ////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            misroute_q <= 1'b0;
        end else if (misroute_q) begin
            misroute_q <= 1'b0;
        end else if (i_awvalid && !(|target) && !i_err_full && !i_sel_full) begin
            misroute_q <= 1'b1;
        end
    end

    assign o_misroute = misroute_q;
    assign o_err_id   = i_awch[ADDR_W +: ID_W];

endmodule

`default_nettype wire

// ==== target_queue.sv ====
////////////////////////////////////////////////////////////
// Small synchronous FIFO, head shown combinationally
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module target_queue #(
    parameter int DEPTH = 4,
    parameter int WIDTH = 8
)(
    input  wire              aclk,
    input  wire              aresetn,
    input  wire              i_push,
    input  wire  [WIDTH-1:0] i_data,
    input  wire              i_pop,
    output logic [WIDTH-1:0] o_data,
    output logic             o_full,
    output logic             o_empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign do_push = i_push & ~o_full;
    assign do_pop  = i_pop & ~o_empty;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Count only moves when exactly one side is active
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (!do_push && do_pop) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_data;
        end
    end

    assign o_data  = mem[rd_ptr];
    assign o_full  = (count == CNT_W'(DEPTH));
    assign o_empty = (count == '0);

endmodule

`default_nettype wire

// ==== w_steering.sv ====
////////////////////////////////////////////////////////////
// Write data routing by the slave mask at the queue head
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module w_steering
    import switch_pkg::*;
(
    input  wire                     i_wvalid,
    input  wire                     i_wlast,
    input  wire        [DATA_W-1:0] i_wch,
    input  wire  slv_mask_t         i_slv_wready,
    input  wire  slv_mask_t         i_sel,
    input  wire                     i_sel_empty,
    output logic                    o_wready,
    output slv_mask_t               o_slv_wvalid,
    output slv_mask_t               o_slv_wlast,
    output logic       [DATA_W-1:0] o_slv_wch,
    output logic                    o_sel_pop
);

    slv_mask_t route;

    // Nothing is routed until an address has been accepted
    assign route = i_sel & {SLV_NB{~i_sel_empty}};

    assign o_slv_wvalid = route & {SLV_NB{i_wvalid}};
    assign o_slv_wlast  = route & {SLV_NB{i_wlast}};
    assign o_slv_wch    = i_wch;

    // Zero mask means decode error, beats are swallowed here
    always_comb begin
        if (i_sel_empty) begin
            o_wready = 1'b0;
        end else if (|i_sel) begin
            o_wready = |(i_sel & i_slv_wready);
        end else begin
            o_wready = 1'b1;
        end
    end

    // Burst done, move on to the next queued route
    assign o_sel_pop = i_wvalid & o_wready & i_wlast;

endmodule

`default_nettype wire

// ==== rr_arbiter.sv ====
////////////////////////////////////////////////////////////
// Round-robin arbiter with a one-hot grant register
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module rr_arbiter #(
    parameter int REQ_NB = 4
)(
    input  wire               aclk,
    input  wire               aresetn,
    input  wire               i_en,
    input  wire  [REQ_NB-1:0] i_req,
    output logic [REQ_NB-1:0] o_grant
);

    localparam int IDX_W = (REQ_NB > 1) ? $clog2(REQ_NB) : 1;

    logic [REQ_NB-1:0] grant_q;
    logic [REQ_NB-1:0] grant_next;
    logic [IDX_W-1:0]  cur_idx;
    logic              found;

    // Index of the current owner
    always_comb begin
        cur_idx = '0;
        for (int k = 0; k < REQ_NB; k++) begin
            if (grant_q[k]) begin
                cur_idx = IDX_W'(k);
            end
        end
    end

    // First active request after the owner, owner itself checked last
    always_comb begin
        grant_next = grant_q;
        found      = 1'b0;
        for (int off = 1; off <= REQ_NB; off++) begin
            if (!found && i_req[(int'(cur_idx) + off) % REQ_NB]) begin
                grant_next = '0;
                grant_next[(int'(cur_idx) + off) % REQ_NB] = 1'b1;
                found = 1'b1;
            end
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            grant_q <= REQ_NB'(1);
        end else if (i_en) begin
            grant_q <= grant_next;
        end
    end

    assign o_grant = grant_q;

endmodule

`default_nettype wire

// ==== b_merge.sv ====
////////////////////////////////////////////////////////////
// Write response merge: queued decode errors first, then
// slave responses picked by round-robin
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module b_merge
    import switch_pkg::*;
(
    input  wire                            aclk,
    input  wire                            aresetn,
    input  wire                            i_bready,
    input  wire  slv_mask_t                i_slv_bvalid,
    input  wire        [SLV_NB*BCH_W-1:0]  i_slv_bch,
    input  wire  id_t                      i_err_id,
    input  wire                            i_err_empty,
    output logic                           o_bvalid,
    output logic       [BCH_W-1:0]         o_bch,
    output slv_mask_t                      o_slv_bready,
    output logic                           o_err_pop
);

    slv_mask_t        grant;
    logic             arb_en;
    logic             slv_valid;
    logic [BCH_W-1:0] slv_bch;
    logic             use_err;
    logic             stall_q;
    logic             src_err_q;

    ////////////////////////////////////////////////////////////
    // Slave side selection
    ////////////////////////////////////////////////////////////

    assign slv_valid = |(grant & i_slv_bvalid);

    always_comb begin
        slv_bch = '0;
        for (int k = 0; k < SLV_NB; k++) begin
            if (grant[k]) begin
                slv_bch = i_slv_bch[k*BCH_W +: BCH_W];
            end
        end
    end

    // Rotate after an accepted response, or skip an idle owner
    assign arb_en = (slv_valid & i_bready & ~use_err) | ~slv_valid;

    rr_arbiter #(
        .REQ_NB (SLV_NB)
    ) u_rr_arbiter (
        .aclk    (aclk),
        .aresetn (aresetn),
        .i_en    (arb_en),
        .i_req   (i_slv_bvalid),
        .o_grant (grant)
    );

    ////////////////////////////////////////////////////////////
    // Source lock while the master stalls
    ////////////////////////////////////////////////////////////

    // A stalled response keeps its source so the word stays stable
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            stall_q   <= 1'b0;
            src_err_q <= 1'b0;
        end else begin
            stall_q   <= o_bvalid & ~i_bready;
            src_err_q <= use_err;
        end
    end

    assign use_err = stall_q ? src_err_q : ~i_err_empty;

    assign o_bvalid = use_err | slv_valid;
    assign o_bch    = use_err ? {RESP_DECERR, i_err_id} : slv_bch;

    assign o_slv_bready = grant & {SLV_NB{i_bready & ~use_err}};
    assign o_err_pop    = use_err & i_bready;

endmodule

`default_nettype wire

// ==== write_switch_top.sv ====
////////////////////////////////////////////////////////////
// Write half of one crossbar master port over four slaves,
// set MST_ROUTES to choose the slaves this master may reach
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module write_switch_top
    import switch_pkg::*;
#(
    parameter slv_mask_t MST_ROUTES = 4'b1011
)(
    input  wire                            aclk,
    input  wire                            aresetn,
    // Master side
    input  wire                            i_awvalid,
    output logic                           o_awready,
    input  wire        [AWCH_W-1:0]        i_awch,
    input  wire                            i_wvalid,
    output logic                           o_wready,
    input  wire                            i_wlast,
    input  wire        [DATA_W-1:0]        i_wch,
    output logic                           o_bvalid,
    input  wire                            i_bready,
    output logic       [BCH_W-1:0]         o_bch,
    // Slave side
    output slv_mask_t                      o_slv_awvalid,
    input  wire  slv_mask_t                i_slv_awready,
    output logic       [AWCH_W-1:0]        o_slv_awch,
    output slv_mask_t                      o_slv_wvalid,
    input  wire  slv_mask_t                i_slv_wready,
    output slv_mask_t                      o_slv_wlast,
    output logic       [DATA_W-1:0]        o_slv_wch,
    input  wire  slv_mask_t                i_slv_bvalid,
    output slv_mask_t                      o_slv_bready,
    input  wire        [SLV_NB*BCH_W-1:0]  i_slv_bch
);

    slv_mask_t sel_in;
    slv_mask_t sel_head;
    logic      sel_push;
    logic      sel_pop;
    logic      sel_full;
    logic      sel_empty;
    id_t       err_id_in;
    id_t       err_id_head;
    logic      err_push;
    logic      err_pop;
    logic      err_full;
    logic      err_empty;

    assign o_slv_awch = i_awch;

    aw_decoder #(
        .MST_ROUTES (MST_ROUTES)
    ) u_aw_decoder (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .i_awvalid     (i_awvalid),
        .i_awch        (i_awch),
        .i_awready_slv (i_slv_awready),
        .i_sel_full    (sel_full),
        .i_err_full    (err_full),
        .o_slv_awvalid (o_slv_awvalid),
        .o_awready     (o_awready),
        .o_sel         (sel_in),
        .o_sel_push    (sel_push),
        .o_misroute    (err_push),
        .o_err_id      (err_id_in)
    );

    // Route of each accepted address, consumed by the data channel
    target_queue #(
        .DEPTH (4),
        .WIDTH (SLV_NB)
    ) u_sel_queue (
        .aclk    (aclk),
        .aresetn (aresetn),
        .i_push  (sel_push),
        .i_data  (sel_in),
        .i_pop   (sel_pop),
        .o_data  (sel_head),
        .o_full  (sel_full),
        .o_empty (sel_empty)
    );

    // IDs waiting for a DECERR response
    target_queue #(
        .DEPTH (4),
        .WIDTH (ID_W)
    ) u_err_queue (
        .aclk    (aclk),
        .aresetn (aresetn),
        .i_push  (err_push),
        .i_data  (err_id_in),
        .i_pop   (err_pop),
        .o_data  (err_id_head),
        .o_full  (err_full),
        .o_empty (err_empty)
    );

    w_steering u_w_steering (
        .i_wvalid     (i_wvalid),
        .i_wlast      (i_wlast),
        .i_wch        (i_wch),
        .i_slv_wready (i_slv_wready),
        .i_sel        (sel_head),
        .i_sel_empty  (sel_empty),
        .o_wready     (o_wready),
        .o_slv_wvalid (o_slv_wvalid),
        .o_slv_wlast  (o_slv_wlast),
        .o_slv_wch    (o_slv_wch),
        .o_sel_pop    (sel_pop)
    );

    b_merge u_b_merge (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .i_bready     (i_bready),
        .i_slv_bvalid (i_slv_bvalid),
        .i_slv_bch    (i_slv_bch),
        .i_err_id     (err_id_head),
        .i_err_empty  (err_empty),
        .o_bvalid     (o_bvalid),
        .o_bch        (o_bch),
        .o_slv_bready (o_slv_bready),
        .o_err_pop    (err_pop)
    );

endmodule

`default_nettype wire

// ==== write_switch_checker.sv ====
////////////////////////////////////////////////////////////
// Protocol assertions, bound into every write switch top
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module write_switch_checker
    import switch_pkg::*;
#(
    parameter slv_mask_t ROUTES = 4'b1011
)(
    input wire              aclk,
    input wire              aresetn,
    input wire              i_awvalid,
    input wire              o_awready,
    input wire [AWCH_W-1:0] i_awch,
    input wire slv_mask_t   o_slv_awvalid,
    input wire [AWCH_W-1:0] o_slv_awch,
    input wire slv_mask_t   o_slv_wvalid,
    input wire              o_wready,
    input wire              o_bvalid,
    input wire              i_bready,
    input wire [BCH_W-1:0]  o_bch,
    input wire slv_mask_t   i_slv_bvalid,
    input wire slv_mask_t   o_slv_bready,
    input wire              err_push
);

    int unsigned fail_count = 0;

    // Strobes reach at most one allowed slave
    aw_onehot: assert property (@(posedge aclk) disable iff (!aresetn)
        $onehot0(o_slv_awvalid) && ((o_slv_awvalid & ~ROUTES) == '0))
    else begin
        fail_count++;
        $error("address strobe on several slaves or on a forbidden slave");
    end

    // Strobed slave is the one that owns the address region
    aw_region: assert property (@(posedge aclk) disable iff (!aresetn)
        (|o_slv_awvalid) |-> i_awvalid &&
            (i_awch[ADDR_W-1:REGION_W] < SLV_NB) &&
            o_slv_awvalid[i_awch[REGION_W +: 2]])
    else begin
        fail_count++;
        $error("slave address strobe without master valid or on the wrong region");
    end

    w_onehot: assert property (@(posedge aclk) disable iff (!aresetn)
        $onehot0(o_slv_wvalid) && ((o_slv_wvalid & ~ROUTES) == '0))
    else begin
        fail_count++;
        $error("data strobe on several slaves or on a forbidden slave");
    end

    // Misroute only answers an address outside the allowed map
    misroute_pulse: assert property (@(posedge aclk) disable iff (!aresetn)
        err_push |-> i_awvalid && o_awready &&
            ((i_awch[ADDR_W-1:REGION_W] >= SLV_NB) ||
             !ROUTES[i_awch[REGION_W +: 2]]))
    else begin
        fail_count++;
        $error("misroute pulse for a mapped address or without master valid");
    end

    b_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        o_bvalid && !i_bready |=> o_bvalid && $stable(o_bch))
    else begin
        fail_count++;
        $error("response dropped or changed while the master stalled");
    end

    // A slave response is taken only as an OKAY the master accepts
    b_stall: assert property (@(posedge aclk) disable iff (!aresetn)
        (|(i_slv_bvalid & o_slv_bready)) |->
            i_bready && o_bvalid && (o_bch[BCH_W-1 -: 2] == RESP_OKAY))
    else begin
        fail_count++;
        $error("slave response taken while the master stalled or not forwarded");
    end

    reset_quiet: assert property (@(posedge aclk)
        !aresetn |-> !o_bvalid && !o_wready && (o_slv_wvalid == '0))
    else begin
        fail_count++;
        $error("response or data handshake active during reset");
    end

endmodule

// Sees the top level ports and its misroute push
bind write_switch_top write_switch_checker #(
    .ROUTES (MST_ROUTES)
) u_checker (.*);

`default_nettype wire

// ==== tb_write_switch.sv ====
////////////////////////////////////////////////////////////
// Testbench for the write switch, random master traffic
// against four slave models with a response scoreboard
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module tb_write_switch
    import switch_pkg::*;
();

    localparam slv_mask_t ROUTES      = 4'b1011;
    localparam int        NTX         = 200;
    localparam int        CYCLE_LIMIT = NTX * 40;

    logic                    aclk;
    logic                    aresetn;
    logic                    i_awvalid;
    logic                    o_awready;
    logic [AWCH_W-1:0]       i_awch;
    logic                    i_wvalid;
    logic                    o_wready;
    logic                    i_wlast;
    logic [DATA_W-1:0]       i_wch;
    logic                    o_bvalid;
    logic                    i_bready;
    logic [BCH_W-1:0]        o_bch;
    slv_mask_t               o_slv_awvalid;
    slv_mask_t               i_slv_awready;
    logic [AWCH_W-1:0]       o_slv_awch;
    slv_mask_t               o_slv_wvalid;
    slv_mask_t               i_slv_wready;
    slv_mask_t               o_slv_wlast;
    logic [DATA_W-1:0]       o_slv_wch;
    slv_mask_t               i_slv_bvalid;
    slv_mask_t               o_slv_bready;
    logic [SLV_NB*BCH_W-1:0] i_slv_bch;

    // Traffic and scoreboard state
    logic [31:0] rng_state;
    int          cycles;
    int          aw_sent;
    int          aw_accepted;
    int          b_done;
    int          beats_left;
    int          pending_len;
    int          exp_cnt [2**BCH_W];
    int          burst_len_q [$];
    slv_mask_t   route_q [$];
    id_t         slv_aw_q [SLV_NB][$];
    id_t         slv_resp_q [SLV_NB][$];
    logic        aw_fire;
    logic        w_fire;
    logic        b_fire;
    slv_mask_t   slv_aw_fire;
    slv_mask_t   slv_w_fire;
    slv_mask_t   slv_b_fire;

    write_switch_top #(
        .MST_ROUTES (ROUTES)
    ) UUT (.*);

    always #10 aclk = ~aclk;

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic end_in_failure(input string what);
        $display("%s", what);
        $display("Verification failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic compare_hex(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            end_in_failure($sformatf("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, want));
        end
    endtask

    initial begin
        aclk          = 1'b0;
        aresetn       = 1'b0;
        rng_state     = 32'd78;
        i_awvalid     = 1'b0;
        i_awch        = '0;
        i_wvalid      = 1'b0;
        i_wlast       = 1'b0;
        i_wch         = '0;
        i_bready      = 1'b0;
        i_slv_awready = '0;
        i_slv_wready  = '0;
        i_slv_bvalid  = '0;
        i_slv_bch     = '0;
        cycles        = 0;
        aw_sent       = 0;
        aw_accepted   = 0;
        b_done        = 0;
        beats_left    = 0;
        pending_len   = 0;
        aw_fire       = 1'b0;
        w_fire        = 1'b0;
        b_fire        = 1'b0;
        slv_aw_fire   = '0;
        slv_w_fire    = '0;
        slv_b_fire    = '0;
        foreach (exp_cnt[i]) begin
            exp_cnt[i] = 0;
        end
        repeat (16) @(posedge aclk);
        aresetn <= 1'b1;
    end

    ////////////////////////////////////////////////////////////
    // Stimulus, driven on the rising edge
    ////////////////////////////////////////////////////////////

    task automatic drive_address();
        addr_t addr;
        id_t   id;
        if (!i_awvalid || aw_fire) begin
            if (aw_sent < NTX && (next_random() % 3) != 0) begin
                addr        = addr_t'(next_random() % 20001);
                id          = id_t'(next_random());
                pending_len = int'(next_random() % 4) + 1;
                aw_sent     = aw_sent + 1;
                i_awvalid  <= 1'b1;
                i_awch     <= {id, addr};
            end else begin
                i_awvalid <= 1'b0;
            end
        end
    endtask

    // Data waits until a few addresses are queued ahead of it
    task automatic drive_data();
        if (w_fire) begin
            beats_left = beats_left - 1;
        end
        if (!i_wvalid || w_fire) begin
            if (beats_left == 0 && burst_len_q.size() > 0 && aw_accepted >= 3) begin
                beats_left = burst_len_q.pop_front();
            end
            if (beats_left > 0 && (next_random() % 4) != 0) begin
                i_wvalid <= 1'b1;
                i_wlast  <= (beats_left == 1);
                i_wch    <= DATA_W'(next_random());
            end else begin
                i_wvalid <= 1'b0;
            end
        end
    endtask

    task automatic drive_slaves();
        for (int k = 0; k < SLV_NB; k++) begin
            i_slv_awready[k] <= (next_random() % 2) == 0;
            i_slv_wready[k]  <= (next_random() % 4) != 0;
            if (slv_resp_q[k].size() > 0) begin
                i_slv_bvalid[k]             <= 1'b1;
                i_slv_bch[k*BCH_W +: BCH_W] <= {RESP_OKAY, slv_resp_q[k][0]};
            end else begin
                i_slv_bvalid[k] <= 1'b0;
            end
        end
    endtask

    always @(posedge aclk) begin
        if (aresetn) begin
            drive_address();
            drive_data();
            i_bready <= (next_random() % 4) != 0;
            drive_slaves();
        end
    end

    ////////////////////////////////////////////////////////////
    // Scoreboard, sampled on the falling edge
    ////////////////////////////////////////////////////////////

    // Region index from the top address bits, allowed routes only
    task automatic check_address();
        addr_t            addr;
        id_t              id;
        int               tgt;
        slv_mask_t        exp_mask;
        logic [BCH_W-1:0] word;
        addr     = i_awch[ADDR_W-1:0];
        id       = i_awch[ADDR_W +: ID_W];
        tgt      = int'(addr >> REGION_W);
        exp_mask = '0;
        if (tgt < SLV_NB && ROUTES[tgt]) begin
            exp_mask[tgt] = 1'b1;
        end
        compare_hex("o_slv_awvalid", 32'(o_slv_awvalid), 32'(exp_mask));
        if (exp_mask != '0) begin
            compare_hex("o_slv_awch", 32'(o_slv_awch), 32'(i_awch));
        end
        word = (exp_mask != '0) ? {RESP_OKAY, id} : {RESP_DECERR, id};
        exp_cnt[int'(word)] = exp_cnt[int'(word)] + 1;
        route_q.push_back(exp_mask);
        burst_len_q.push_back(pending_len);
        aw_accepted = aw_accepted + 1;
    endtask

    task automatic check_beat();
        slv_mask_t exp_mask;
        if (route_q.size() == 0) begin
            end_in_failure("write beat accepted with no address outstanding");
        end else begin
            exp_mask = route_q[0];
            compare_hex("o_slv_wvalid", 32'(o_slv_wvalid), 32'(exp_mask));
            compare_hex("o_slv_wlast", 32'(o_slv_wlast),
                        32'(i_wlast ? exp_mask : slv_mask_t'(0)));
            if (exp_mask != '0) begin
                compare_hex("o_slv_wch", 32'(o_slv_wch), 32'(i_wch));
            end
            if (i_wlast) begin
                void'(route_q.pop_front());
            end
        end
    endtask

    // Slave models answer OKAY with the address ID after the last beat
    task automatic update_slaves();
        for (int k = 0; k < SLV_NB; k++) begin
            if (slv_b_fire[k]) begin
                void'(slv_resp_q[k].pop_front());
            end
            if (slv_aw_fire[k]) begin
                slv_aw_q[k].push_back(id_t'(o_slv_awch[ADDR_W +: ID_W]));
            end
            if (slv_w_fire[k] && o_slv_wlast[k]) begin
                if (slv_aw_q[k].size() == 0) begin
                    end_in_failure($sformatf("slave %0d got a last beat with no address", k));
                end else begin
                    slv_resp_q[k].push_back(slv_aw_q[k].pop_front());
                end
            end
        end
    endtask

    task automatic check_response();
        if (exp_cnt[int'(o_bch)] == 0) begin
            end_in_failure($sformatf("MISMATCH o_bch: got 0x%0h, no such response is due", o_bch));
        end else begin
            exp_cnt[int'(o_bch)] = exp_cnt[int'(o_bch)] - 1;
            b_done = b_done + 1;
        end
    endtask

    task automatic finish_run();
        int left;
        left = burst_len_q.size();
        for (int k = 0; k < SLV_NB; k++) begin
            left = left + slv_aw_q[k].size() + slv_resp_q[k].size();
        end
        if (left != 0) begin
            end_in_failure($sformatf("%0d queued items left after the last response", left));
        end else begin
            $display("Verification passed");
            $finish;
        end
    endtask

    always @(negedge aclk) begin
        aw_fire     = i_awvalid & o_awready;
        w_fire      = i_wvalid & o_wready;
        b_fire      = o_bvalid & i_bready;
        slv_aw_fire = o_slv_awvalid & i_slv_awready;
        slv_w_fire  = o_slv_wvalid & i_slv_wready;
        slv_b_fire  = i_slv_bvalid & o_slv_bready;
        if (UUT.u_checker.fail_count != 0) begin
            end_in_failure("a concurrent assertion in the checker failed");
        end
        if (aw_fire) begin
            check_address();
        end
        if (w_fire) begin
            check_beat();
        end
        update_slaves();
        if (b_fire) begin
            check_response();
        end
        if (aresetn) begin
            cycles = cycles + 1;
        end
        if (b_done == NTX && route_q.size() == 0) begin
            finish_run();
        end else if (cycles >= CYCLE_LIMIT) begin
            end_in_failure($sformatf("timeout after %0d cycles, %0d of %0d responses seen",
                                     cycles, b_done, NTX));
        end
    end

endmodule

`default_nettype wire

// ==== all.f ====
switch_pkg.sv
aw_decoder.sv
target_queue.sv
w_steering.sv
rr_arbiter.sv
b_merge.sv
write_switch_top.sv
write_switch_checker.sv
tb_write_switch.sv

// ==== Makefile ====
TOP = tb_write_switch
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f all.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f all.f -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	grep -q "^Verification passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
